//--- fcs_stripper.sv
// Delay line that holds back the last FCS_LEN bytes of each frame.
// Output lags the sampled stream by FCS_LEN+1 cycles.

`timescale 1ns/1ps
`default_nettype none

module fcs_stripper (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gmii_rx_pkg::gmii_beat_t sampled,
    input  logic                    sof,
    input  logic                    eof,
    output gmii_rx_pkg::gmii_beat_t stripped
);

    logic [gmii_rx_pkg::FCS_LEN-1:0] dv_q;
    logic [gmii_rx_pkg::FCS_LEN-1:0] er_q;
    gmii_rx_pkg::byte_t              data_q [gmii_rx_pkg::FCS_LEN];
    gmii_rx_pkg::fcs_cnt_t           fill_cnt;
    logic                            out_dv;
    logic                            out_er;
    gmii_rx_pkg::byte_t              out_data;

    ////////////////////////////////////////////////////////////////////////////
    // Control bits and fill level
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dv_q     <= '0;
            er_q     <= '0;
            fill_cnt <= '0;
            out_dv   <= 1'b0;
            out_er   <= 1'b0;
        end else if (eof) begin
            // Line now holds only FCS bytes, drop them
            dv_q     <= '0;
            er_q     <= '0;
            fill_cnt <= '0;
            out_dv   <= 1'b0;
            out_er   <= 1'b0;
        end else begin
            dv_q   <= {dv_q[gmii_rx_pkg::FCS_LEN-2:0], sampled.dv};
            er_q   <= {er_q[gmii_rx_pkg::FCS_LEN-2:0], sampled.er};
            out_dv <= dv_q[gmii_rx_pkg::FCS_LEN-1] && (fill_cnt == gmii_rx_pkg::FCS_FULL);
            out_er <= er_q[gmii_rx_pkg::FCS_LEN-1] && (fill_cnt == gmii_rx_pkg::FCS_FULL);
            if (sof) begin
                fill_cnt <= gmii_rx_pkg::fcs_cnt_t'(1);
            end else if (sampled.dv && fill_cnt != gmii_rx_pkg::FCS_FULL) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // Byte shift register
    always_ff @(posedge clk) begin
        data_q[0] <= sampled.data;
        for (int i = 1; i < gmii_rx_pkg::FCS_LEN; i++) begin
            data_q[i] <= data_q[i-1];
        end
        out_data <= data_q[gmii_rx_pkg::FCS_LEN-1];
    end

    assign stripped = '{dv: out_dv, er: out_er, data: out_data};

    a_no_early_out: assert property (@(posedge clk) disable iff (!rst_n)
        !(out_dv && fill_cnt < gmii_rx_pkg::FCS_FULL))
        else $error("stripped.dv high before the delay line is full");

endmodule

`default_nettype wire

//--- frame_length_ctrl.sv
// Checks preamble and SFD, then forwards the payload held to 60..1514 bytes.
// Short frames get zero padding, long frames are cut, bad preambles dropped.

`timescale 1ns/1ps
`default_nettype none

module frame_length_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gmii_rx_pkg::gmii_beat_t stripped,
    input  logic                    eof,
    output gmii_rx_pkg::gmii_beat_t rx_out
);

    gmii_rx_pkg::len_state_t state;
    gmii_rx_pkg::frame_len_t byte_cnt;
    gmii_rx_pkg::frame_len_t cnt_next;
    logic                    out_dv;
    logic                    out_er;
    gmii_rx_pkg::byte_t      out_data;

    assign cnt_next = byte_cnt + 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Length FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= gmii_rx_pkg::LEN_IDLE;
            byte_cnt <= '0;
            out_dv   <= 1'b0;
            out_er   <= 1'b0;
        end else begin
            out_dv <= 1'b0;
            out_er <= 1'b0;
            case (state)
                gmii_rx_pkg::LEN_IDLE: begin
                    if (stripped.dv) begin
                        if (stripped.data == gmii_rx_pkg::PREAMBLE_BYTE) begin
                            state <= gmii_rx_pkg::LEN_PREAMBLE;
                        end else begin
                            state <= gmii_rx_pkg::LEN_DRAIN;
                        end
                    end
                end
                gmii_rx_pkg::LEN_PREAMBLE: begin
                    if (!stripped.dv) begin
                        state <= gmii_rx_pkg::LEN_IDLE;
                    end else if (stripped.data == gmii_rx_pkg::SFD_BYTE) begin
                        state    <= gmii_rx_pkg::LEN_PASS;
                        byte_cnt <= '0;
                    end else if (stripped.data != gmii_rx_pkg::PREAMBLE_BYTE) begin
                        state <= gmii_rx_pkg::LEN_DRAIN;
                    end
                end
                gmii_rx_pkg::LEN_PASS: begin
                    if (stripped.dv) begin
                        out_dv   <= 1'b1;
                        out_er   <= stripped.er;
                        byte_cnt <= cnt_next;
                        // eof lines up with the last non-FCS byte
                        if (eof) begin
                            if (cnt_next < gmii_rx_pkg::MIN_FRAME_LEN) begin
                                state <= gmii_rx_pkg::LEN_PAD;
                            end else begin
                                state <= gmii_rx_pkg::LEN_IDLE;
                            end
                        end else if (cnt_next == gmii_rx_pkg::MAX_FRAME_LEN) begin
                            state <= gmii_rx_pkg::LEN_DRAIN;
                        end
                    end else begin
                        state <= gmii_rx_pkg::LEN_IDLE;
                    end
                end
                gmii_rx_pkg::LEN_PAD: begin
                    out_dv   <= 1'b1;
                    byte_cnt <= cnt_next;
                    if (cnt_next == gmii_rx_pkg::MIN_FRAME_LEN) begin
                        state <= gmii_rx_pkg::LEN_IDLE;
                    end
                end
                gmii_rx_pkg::LEN_DRAIN: begin
                    // Swallow the rest of the frame
                    if (!stripped.dv) begin
                        state <= gmii_rx_pkg::LEN_IDLE;
                    end
                end
                default: begin
                    state <= gmii_rx_pkg::LEN_IDLE;
                end
            endcase
        end
    end

    // Payload byte, zero while padding
    always_ff @(posedge clk) begin
        if (state == gmii_rx_pkg::LEN_PASS) begin
            out_data <= stripped.data;
        end else begin
            out_data <= '0;
        end
    end

    assign rx_out = '{dv: out_dv, er: out_er, data: out_data};

    a_max_len: assert property (@(posedge clk) disable iff (!rst_n)
        out_dv |-> (byte_cnt != '0 && byte_cnt <= gmii_rx_pkg::MAX_FRAME_LEN))
        else $error("output frame longer than MAX_FRAME_LEN");

endmodule

`default_nettype wire

//--- gmii_rx_ctrl.sv
// Top level of the GMII receive front end.
// Sampler, FCS stripper and length controller in a chain.

`timescale 1ns/1ps
`default_nettype none

module gmii_rx_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gmii_rx_pkg::gmii_beat_t rx_in,
    output gmii_rx_pkg::gmii_beat_t rx_out
);

    gmii_rx_pkg::gmii_beat_t sampled;
    gmii_rx_pkg::gmii_beat_t stripped;
    logic                    sof;
    logic                    eof;

    gmii_rx_sampler u_sampler (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_in   (rx_in),
        .sampled (sampled),
        .sof     (sof),
        .eof     (eof)
    );

    fcs_stripper u_stripper (
        .clk      (clk),
        .rst_n    (rst_n),
        .sampled  (sampled),
        .sof      (sof),
        .eof      (eof),
        .stripped (stripped)
    );

    frame_length_ctrl u_len_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .stripped (stripped),
        .eof      (eof),
        .rx_out   (rx_out)
    );

endmodule

`default_nettype wire

//--- gmii_rx_pkg.sv
// Shared types and constants for the GMII receive front end.
// RTL files reach these by scoped names.

`default_nettype none

package gmii_rx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0]  byte_t;
    typedef logic [10:0] frame_len_t;

    // One clock of the GMII stream
    typedef struct packed {
        logic  dv;
        logic  er;
        byte_t data;
    } gmii_beat_t;

    ////////////////////////////////////////////////////////////////////////////
    // Frame limits and codes
    ////////////////////////////////////////////////////////////////////////////

    // Output length limits, FCS excluded
    localparam frame_len_t MIN_FRAME_LEN = 11'd60;
    localparam frame_len_t MAX_FRAME_LEN = 11'd1514;

    localparam int FCS_LEN   = 4;
    localparam int FCS_CNT_W = $clog2(FCS_LEN + 1);

    // Fill level of the FCS delay line
    typedef logic [FCS_CNT_W-1:0] fcs_cnt_t;
    localparam fcs_cnt_t FCS_FULL = fcs_cnt_t'(FCS_LEN);

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    // Length controller states
    typedef enum logic [2:0] {
        LEN_IDLE,
        LEN_PREAMBLE,
        LEN_PASS,
        LEN_PAD,
        LEN_DRAIN
    } len_state_t;

endpackage

`default_nettype wire

//--- gmii_rx_sampler.sv
// Input register stage for the PHY receive signals.
// Also marks the first and the first idle cycle of each frame.

`timescale 1ns/1ps
`default_nettype none

module gmii_rx_sampler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gmii_rx_pkg::gmii_beat_t rx_in,
    output gmii_rx_pkg::gmii_beat_t sampled,
    output logic                    sof,
    output logic                    eof
);

    logic               dv_q;
    logic               er_q;
    logic               dv_prev;
    gmii_rx_pkg::byte_t data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dv_q    <= 1'b0;
            er_q    <= 1'b0;
            dv_prev <= 1'b0;
        end else begin
            dv_q    <= rx_in.dv;
            er_q    <= rx_in.er;
            dv_prev <= dv_q;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= rx_in.data;
    end

    assign sampled = '{dv: dv_q, er: er_q, data: data_q};

    // Edges of the registered dv
    assign sof = dv_q & ~dv_prev;
    assign eof = ~dv_q & dv_prev;

    a_sof_eof_excl: assert property (@(posedge clk) disable iff (!rst_n) !(sof && eof))
        else $error("sof and eof high in the same cycle");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the GMII receive testbench with Verilator.
# Exits non-zero when the build, the run or the testbench check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_gmii_rx_ctrl

verilator --binary --assert --top-module "$TOP" -Mdir "$OBJ" -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
    echo "No pass message found in $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- sources.f
gmii_rx_pkg.sv
gmii_rx_sampler.sv
fcs_stripper.sv
frame_length_ctrl.sv
gmii_rx_ctrl.sv
tb_gmii_rx_ctrl.sv

//--- tb_gmii_rx_ctrl.sv
// Testbench for the GMII receive front end.
// Sends framed byte streams and checks rx_out against a queue of expected bytes.

`timescale 1ns/1ps
`default_nettype none

module tb_gmii_rx_ctrl;

    // One expected output beat, last marks the final byte of a frame
    typedef struct packed {
        logic               last;
        logic               er;
        gmii_rx_pkg::byte_t data;
    } exp_beat_t;

    logic                    clk;
    logic                    rst_n;
    gmii_rx_pkg::gmii_beat_t rx_in;
    gmii_rx_pkg::gmii_beat_t rx_out;

    exp_beat_t exp_q [$];
    exp_beat_t head;
    logic      prev_dv;
    logic      prev_last;
    int        out_idx;
    int        mismatch_cnt = 0;
    int        timeout_cnt  = 0;
    int        missing_cnt  = 0;
    bit        timed_out    = 1'b0;

    gmii_rx_ctrl UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx_in  (rx_in),
        .rx_out (rx_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic drive_beat(input logic dv, input logic er, input gmii_rx_pkg::byte_t data);
        @(posedge clk);
        rx_in <= '{dv: dv, er: er, data: data};
    endtask

    task automatic wait_frame_out(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected output bytes still pending after %0d cycles",
                     exp_q.size(), max_cycles);
            timeout_cnt++;
            timed_out = 1'b1;
        end
    endtask

    task automatic send_frame(input int payload_len, input bit bad_pre, input bit no_sfd,
                              input int er_pos);
        gmii_rx_pkg::byte_t payload [$];
        exp_beat_t          beat;
        int                 out_len;
        if (timed_out) begin
            return;
        end
        for (int i = 0; i < payload_len; i++) begin
            payload.push_back(gmii_rx_pkg::byte_t'($urandom));
        end
        // Without an SFD the first payload byte must not pass for preamble or SFD
        if (no_sfd && (payload[0] == 8'h55 || payload[0] == 8'hD5)) begin
            payload[0] = 8'hA7;
        end

        // Reference: payload held to 60..1514 bytes, nothing for a bad header
        if (!bad_pre && !no_sfd) begin
            out_len = payload_len;
            if (out_len < 60) begin
                out_len = 60;
            end else if (out_len > 1514) begin
                out_len = 1514;
            end
            for (int i = 0; i < out_len; i++) begin
                beat.last = (i == out_len - 1);
                beat.er   = (i < payload_len) && (i == er_pos);
                beat.data = (i < payload_len) ? payload[i] : 8'h00;
                exp_q.push_back(beat);
            end
        end

        for (int i = 0; i < 7; i++) begin
            drive_beat(1'b1, 1'b0, (i == 0 && bad_pre) ? 8'h5A : 8'h55);
        end
        if (!no_sfd) begin
            drive_beat(1'b1, 1'b0, 8'hD5);
        end
        for (int i = 0; i < payload_len; i++) begin
            drive_beat(1'b1, (i == er_pos), payload[i]);
        end
        // FCS bytes, any value
        for (int i = 0; i < 4; i++) begin
            drive_beat(1'b1, 1'b0, gmii_rx_pkg::byte_t'($urandom));
        end
        drive_beat(1'b0, 1'b0, 8'h00);
        repeat (64) @(posedge clk);
        wait_frame_out(200);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output checker
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            prev_dv   = 1'b0;
            prev_last = 1'b0;
            out_idx   = 0;
        end else begin
            if (rx_out.dv) begin
                if (!prev_dv) begin
                    out_idx = 0;
                end
                assert (!(prev_dv && prev_last)) else begin
                    $display("MISMATCH at %t: output frame runs past its expected length",
                             $time);
                    mismatch_cnt++;
                end
                assert (exp_q.size() != 0) else begin
                    $display("MISMATCH at %t: output byte 0x%02h with no byte expected",
                             $time, rx_out.data);
                    mismatch_cnt++;
                end
                if (exp_q.size() != 0) begin
                    head = exp_q.pop_front();
                    assert (rx_out.data == head.data && rx_out.er == head.er) else begin
                        $display({"MISMATCH at %t: byte %0d is 0x%02h er=%0b, ",
                                  "expected 0x%02h er=%0b"},
                                 $time, out_idx, rx_out.data, rx_out.er, head.data, head.er);
                        mismatch_cnt++;
                    end
                    prev_last = head.last;
                end
                out_idx++;
            end else begin
                assert (!rx_out.er) else begin
                    $display("MISMATCH at %t: er high while dv is low", $time);
                    mismatch_cnt++;
                end
                assert (!(prev_dv && !prev_last)) else begin
                    $display("MISMATCH at %t: output frame ended after %0d bytes, too early",
                             $time, out_idx);
                    mismatch_cnt++;
                end
            end
            prev_dv = rx_out.dv;
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(49));
        rst_n = 1'b0;
        rx_in = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // Idle line after reset
        repeat (30) @(posedge clk);

        send_frame(64, 1'b0, 1'b0, -1);
        send_frame(150, 1'b0, 1'b0, -1);
        send_frame(300, 1'b0, 1'b0, -1);
        // Short payloads get zero padding
        send_frame(1, 1'b0, 1'b0, -1);
        send_frame(20, 1'b0, 1'b0, -1);
        send_frame(59, 1'b0, 1'b0, -1);
        send_frame(60, 1'b0, 1'b0, -1);
        // Long payloads are cut
        send_frame(1515, 1'b0, 1'b0, -1);
        send_frame(1600, 1'b0, 1'b0, 1513);
        // Bad header, then a clean frame
        send_frame(80, 1'b1, 1'b0, -1);
        send_frame(80, 1'b0, 1'b1, -1);
        send_frame(100, 1'b0, 1'b0, -1);
        // er kept at its byte position
        send_frame(100, 1'b0, 1'b0, 37);
        send_frame(30, 1'b0, 1'b0, 29);
        for (int k = 0; k < 4; k++) begin
            send_frame(1 + int'($urandom % 400), 1'b0, 1'b0, -1);
        end
        repeat (20) @(posedge clk);

        assert (exp_q.size() == 0) else begin
            $display("Frames incomplete: %0d expected output bytes never appeared",
                     exp_q.size());
            missing_cnt = exp_q.size();
        end
        $display("Errors: %0d mismatches, %0d timeouts, %0d missing bytes",
                 mismatch_cnt, timeout_cnt, missing_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0 && missing_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
